// ==== sim.f ====
+incdir+common
common/chess_pkg.sv
common/eval_stage_if.sv
logic/eval_ctrl.sv
evaluate/square_scorer.sv
evaluate/score_adder_tree.sv
evaluate/board_evaluator.sv
sim/tb_board_evaluator.sv

// ==== Bender.yml ====
package:
  name: board_evaluator

export_include_dirs:
  - common

sources:
  - files:
      - common/chess_pkg.sv
      - common/eval_stage_if.sv
      - logic/eval_ctrl.sv
      - evaluate/square_scorer.sv
      - evaluate/score_adder_tree.sv
      - evaluate/board_evaluator.sv

  - target: simulation
    files:
      - sim/tb_board_evaluator.sv

// ==== sim/tb_board_evaluator.sv ====
`default_nettype none

`include "eval_cfg.svh"

module tb_board_evaluator;

   timeunit 1ns;
   timeprecision 1ps;

   import chess_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 16;
   localparam int NUM_DIRECTED = 13;
   localparam int NUM_RANDOM   = 40;
   localparam int NUM_TESTS    = NUM_DIRECTED + NUM_RANDOM;
   localparam int WAIT_LIMIT   = 12;

   logic   clk = 1'b0;
   logic   reset;
   logic   board_valid;
   board_t board_in;
   logic   clear_eval;
   eval_t  eval;
   logic   eval_valid;

   int value_errors = 0;
   int other_errors = 0;
   int results_seen = 0;

   always #(CLK_PERIOD / 2) clk = ~clk;

   board_evaluator dut0 (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .board_in    (board_in),
      .clear_eval  (clear_eval),
      .eval        (eval),
      .eval_valid  (eval_valid)
   );

   // ------------------------------------------------------------------------
   // Reference and checks
   // ------------------------------------------------------------------------

   // Kind 1 is a pawn, kind 6 a king.
   function automatic int material(input int kind);
      case (kind)
         1:       return `VALUE_PAWN;
         2:       return `VALUE_KNIGHT;
         3:       return `VALUE_BISHOP;
         4:       return `VALUE_ROOK;
         5:       return `VALUE_QUEEN;
         6:       return `VALUE_KING;
         default: return 0;
      endcase
   endfunction

   function automatic eval_t ref_eval(input board_t board);
      int total;
      int code;
      total = 0;
      for (int s = 0; s < `NUM_SQUARES; s++)
      begin
         code = int'(board[s*`PIECE_BITS +: `PIECE_BITS]);
         if (code >= 1 && code <= 6)
            total += material(code);
         else if (code >= 9 && code <= 14)
            total -= material(code - 8);
      end
      return eval_t'(total);
   endfunction

   task automatic check_eval(input eval_t actual, input eval_t expected);
      if (actual !== expected)
      begin
         value_errors++;
         $display("Fail %t: eval is %0d, expected %0d", $time, actual, expected);
      end
   endtask

   task automatic check_valid(input logic actual, input logic expected);
      if (actual !== expected)
      begin
         value_errors++;
         $display("Fail %t: eval_valid is %b, expected %b", $time, actual, expected);
      end
   endtask

   // Stage sequence model. Inputs are read at the rising edge, outputs half a
   // cycle later.
   eval_state_t model_state;
   eval_t       exp_eval;
   logic        exp_valid;
   logic        armed = 1'b0;

   always
   begin
      @(posedge clk);
      if (reset)
      begin
         model_state = IDLE;
         exp_valid   = 1'b0;
         armed       = 1'b1;
      end
      else
      begin
         exp_valid = (model_state == DONE);
         case (model_state)
            IDLE:
            begin
               if (board_valid)
               begin
                  exp_eval    = ref_eval(board_in);
                  model_state = SCORE;
               end
            end
            SCORE:     model_state = SUM_ROWS;
            SUM_ROWS:  model_state = SUM_PAIRS;
            SUM_PAIRS: model_state = DONE;
            default:
            begin
               if (clear_eval)
                  model_state = IDLE;
            end
         endcase
      end
      @(negedge clk);
      if (armed)
      begin
         check_valid(eval_valid, exp_valid);
         if (exp_valid)
            check_eval(eval, exp_eval);
      end
   end

   // ------------------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------------------

   function automatic board_t random_board();
      board_t b;
      for (int w = 0; w < 8; w++)
         b[32*w +: 32] = $urandom();
      return b;
   endfunction

   // Each code meets its opposite colour, so the sides cancel.
   function automatic board_t mirrored_board();
      board_t     b;
      logic [3:0] code;
      for (int s = 0; s < 32; s++)
      begin
         code = 4'($urandom_range(0, 15));
         b[4*s +: 4] = code;
         b[4*(63 - s) +: 4] = code ^ 4'd8;
      end
      return b;
   endfunction

   function automatic board_t single_piece(input logic [3:0] code);
      board_t b;
      int     sq;
      b  = '0;
      sq = $urandom_range(0, 63);
      b[4*sq +: 4] = code;
      return b;
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         board_in = random_board();
         @(negedge clk);
      end
   endtask

   task automatic run_board(input board_t board);
      int wait_count;
      int hold;
      board_valid = 1'b1;
      board_in    = board;
      @(negedge clk);
      board_valid = 1'b0;
      board_in    = random_board();
      wait_count  = 0;
      while (eval_valid !== 1'b1 && wait_count < WAIT_LIMIT)
      begin
         @(negedge clk);
         wait_count++;
      end
      if (eval_valid !== 1'b1)
      begin
         other_errors++;
         $display("No result came out within %0d cycles of a board", WAIT_LIMIT);
      end
      else
         results_seen++;
      // Boards offered while the result is held should be dropped.
      hold = $urandom_range(0, 10);
      repeat (hold)
      begin
         board_valid = 1'($urandom_range(0, 1));
         board_in    = random_board();
         @(negedge clk);
      end
      board_valid = 1'b0;
      clear_eval  = 1'b1;
      @(negedge clk);
      clear_eval  = 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'h8045_36b5));
      $timeformat(-9, 0, " ns", 1);
      reset       = 1'b1;
      board_valid = 1'b0;
      board_in    = '0;
      clear_eval  = 1'b0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      idle_cycles(8);
      run_board('0);
      for (int code = 1; code <= 14; code++)
      begin
         if (code != 7 && code != 8)
         begin
            idle_cycles($urandom_range(0, 2));
            run_board(single_piece(4'(code)));
         end
      end
      for (int t = 0; t < NUM_RANDOM; t++)
      begin
         // Zero idle cycles sends the board back to back.
         idle_cycles($urandom_range(0, 2));
         if (t % 2 == 0)
            run_board(random_board());
         else
            run_board(mirrored_board());
      end
      idle_cycles(4);
      if (results_seen != NUM_TESTS)
      begin
         other_errors++;
         $display("Only %0d of %0d boards produced a result", results_seen, NUM_TESTS);
      end
      $display("value errors: %0d, other errors: %0d, results checked: %0d",
               value_errors, other_errors, results_seen);
      if (value_errors == 0 && other_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   initial
   begin
      #((RESET_CYCLES + NUM_TESTS * 20) * CLK_PERIOD);
      $display("Watchdog expired before all boards were evaluated");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== evaluate/board_evaluator.sv ====
`default_nettype none

`include "eval_cfg.svh"

module board_evaluator (
   input  logic              clk,
   input  logic              reset,

   input  logic              board_valid,
   input  chess_pkg::board_t board_in,
   input  logic              clear_eval,

   output chess_pkg::eval_t  eval,
   output logic              eval_valid
);

   import chess_pkg::*;

   eval_stage_if stage_bus ();

   score_t square_scores [`NUM_SQUARES];

   eval_ctrl u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .stage       (stage_bus.ctrl),
      .eval_valid  (eval_valid)
   );

   // Board register and per-square material lookup.
   square_scorer u_scorer (
      .clk      (clk),
      .board_in (board_in),
      .stage    (stage_bus.datapath),
      .scores   (square_scores)
   );

   // Three summing levels and the held result.
   score_adder_tree u_tree (
      .clk    (clk),
      .stage  (stage_bus.datapath),
      .scores (square_scores),
      .eval   (eval)
   );

endmodule

`default_nettype wire

// ==== evaluate/score_adder_tree.sv ====
`default_nettype none

`include "eval_cfg.svh"

module score_adder_tree (
   input  logic              clk,
   eval_stage_if.datapath    stage,
   input  chess_pkg::score_t scores [`NUM_SQUARES],
   output chess_pkg::eval_t  eval
);

   import chess_pkg::*;

   // Two half-rank sums per rank, then one sum per pair of ranks.
   eval_t sum_rows  [16];
   eval_t sum_pairs [4];

   // ------------------------------------------------------------------------
   // Level 1: four squares each
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (stage.sum_rows_en)
      begin
         for (int h = 0; h < 16; h++)
         begin
            sum_rows[h] <= eval_t'(scores[4*h])
                         + eval_t'(scores[4*h + 1])
                         + eval_t'(scores[4*h + 2])
                         + eval_t'(scores[4*h + 3]);
         end
      end
   end

   // ------------------------------------------------------------------------
   // Level 2: two ranks each
   // ------------------------------------------------------------------------

   always_ff @(posedge clk)
   begin
      if (stage.sum_pairs_en)
      begin
         for (int p = 0; p < 4; p++)
         begin
            sum_pairs[p] <= sum_rows[4*p]
                          + sum_rows[4*p + 1]
                          + sum_rows[4*p + 2]
                          + sum_rows[4*p + 3];
         end
      end
   end

   // ------------------------------------------------------------------------
   // Level 3: whole board
   // ------------------------------------------------------------------------

   // Reloaded every DONE cycle while its inputs stand still.
   always_ff @(posedge clk)
   begin
      if (stage.final_en)
         eval <= sum_pairs[0] + sum_pairs[1] + sum_pairs[2] + sum_pairs[3];
   end

   one_level_at_a_time: assert property (@(posedge clk)
      $onehot0({stage.sum_rows_en, stage.sum_pairs_en, stage.final_en}));

endmodule

`default_nettype wire

// ==== evaluate/square_scorer.sv ====
`default_nettype none

`include "eval_cfg.svh"

module square_scorer (
   input  logic              clk,
   input  chess_pkg::board_t board_in,
   eval_stage_if.datapath    stage,
   output chess_pkg::score_t scores [`NUM_SQUARES]
);

   import chess_pkg::*;

   board_t board;

   // Signed material value, white positive.
   function automatic score_t piece_value(input piece_t piece);
      case (piece)
         WHITE_PAWN:   piece_value = score_t'(`VALUE_PAWN);
         WHITE_KNIGHT: piece_value = score_t'(`VALUE_KNIGHT);
         WHITE_BISHOP: piece_value = score_t'(`VALUE_BISHOP);
         WHITE_ROOK:   piece_value = score_t'(`VALUE_ROOK);
         WHITE_QUEEN:  piece_value = score_t'(`VALUE_QUEEN);
         WHITE_KING:   piece_value = score_t'(`VALUE_KING);
         BLACK_PAWN:   piece_value = score_t'(-`VALUE_PAWN);
         BLACK_KNIGHT: piece_value = score_t'(-`VALUE_KNIGHT);
         BLACK_BISHOP: piece_value = score_t'(-`VALUE_BISHOP);
         BLACK_ROOK:   piece_value = score_t'(-`VALUE_ROOK);
         BLACK_QUEEN:  piece_value = score_t'(-`VALUE_QUEEN);
         BLACK_KING:   piece_value = score_t'(-`VALUE_KING);
         // Empty and unused codes.
         default:      piece_value = '0;
      endcase
   endfunction

   always_ff @(posedge clk)
   begin
      if (stage.load_board)
         board <= board_in;
   end

   // All 64 lookups in one cycle.
   always_ff @(posedge clk)
   begin
      if (stage.score_en)
      begin
         for (int s = 0; s < `NUM_SQUARES; s++)
            scores[s] <= piece_value(piece_t'(board[s*`PIECE_BITS +: `PIECE_BITS]));
      end
   end

   // Board must be stable while it is being scored.
   no_load_while_scoring: assert property (@(posedge clk)
      stage.score_en |-> !stage.load_board);

endmodule

`default_nettype wire

// ==== logic/eval_ctrl.sv ====
`default_nettype none

module eval_ctrl (
   input  logic       clk,
   input  logic       reset,
   input  logic       board_valid,
   input  logic       clear_eval,
   eval_stage_if.ctrl stage,
   output logic       eval_valid
);

   import chess_pkg::*;

   eval_state_t state;
   eval_state_t state_next;

   // ------------------------------------------------------------------------
   // State sequence
   // ------------------------------------------------------------------------

   always_comb
   begin
      state_next = state;
      case (state)
         IDLE:
         begin
            if (board_valid)
               state_next = SCORE;
         end
         SCORE:     state_next = SUM_ROWS;
         SUM_ROWS:  state_next = SUM_PAIRS;
         SUM_PAIRS: state_next = DONE;
         DONE:
         begin
            // Result holds here until the host clears it.
            if (clear_eval)
               state_next = IDLE;
         end
         default:   state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= IDLE;
         eval_valid <= 1'b0;
      end
      else
      begin
         state      <= state_next;
         eval_valid <= (state == DONE);
      end
   end

   // Board register follows board_in for as long as we sit in IDLE.
   assign stage.load_board   = (state == IDLE);
   assign stage.score_en     = (state == SCORE);
   assign stage.sum_rows_en  = (state == SUM_ROWS);
   assign stage.sum_pairs_en = (state == SUM_PAIRS);
   assign stage.final_en     = (state == DONE);

   state_legal: assert property (@(posedge clk) disable iff (reset)
      state inside {IDLE, SCORE, SUM_ROWS, SUM_PAIRS, DONE});

   // Valid rises four cycles after the edge that took the board.
   valid_latency: assert property (@(posedge clk) disable iff (reset)
      $rose(eval_valid) |-> $past(state == IDLE && board_valid, 5));

endmodule

`default_nettype wire

// ==== common/eval_stage_if.sv ====
`default_nettype none

// Stage strobes from the evaluation FSM to the datapath.
interface eval_stage_if;

   logic load_board;
   logic score_en;
   logic sum_rows_en;
   logic sum_pairs_en;
   logic final_en;

   modport ctrl (
      output load_board, score_en, sum_rows_en, sum_pairs_en, final_en
   );

   modport datapath (
      input load_board, score_en, sum_rows_en, sum_pairs_en, final_en
   );

endinterface

`default_nettype wire

// ==== common/chess_pkg.sv ====
`default_nettype none

`include "eval_cfg.svh"

package chess_pkg;

   // Piece codes. 7, 8 and 15 are unused.
   typedef enum logic [`PIECE_BITS-1:0] {
      EMPTY        = 4'd0,
      WHITE_PAWN   = 4'd1,
      WHITE_KNIGHT = 4'd2,
      WHITE_BISHOP = 4'd3,
      WHITE_ROOK   = 4'd4,
      WHITE_QUEEN  = 4'd5,
      WHITE_KING   = 4'd6,
      BLACK_PAWN   = 4'd9,
      BLACK_KNIGHT = 4'd10,
      BLACK_BISHOP = 4'd11,
      BLACK_ROOK   = 4'd12,
      BLACK_QUEEN  = 4'd13,
      BLACK_KING   = 4'd14
   } piece_t;

   // Square s = 8 * rank + file sits at bits 4s+3:4s.
   typedef logic [`NUM_SQUARES*`PIECE_BITS-1:0] board_t;

   typedef logic signed [15:0] score_t;

   // Partial sums and the final result.
   typedef logic signed [`EVAL_WIDTH-1:0] eval_t;

   typedef enum logic [2:0] {
      IDLE,
      SCORE,
      SUM_ROWS,
      SUM_PAIRS,
      DONE
   } eval_state_t;

endpackage

`default_nettype wire

// ==== common/eval_cfg.svh ====
`ifndef EVAL_CFG_SVH
`define EVAL_CFG_SVH

// ---------------------------------------------------------------------------
// Board geometry
// ---------------------------------------------------------------------------

// Bits per square and squares per board.
`define PIECE_BITS  4
`define NUM_SQUARES 64

// Width of the signed evaluation result.
`define EVAL_WIDTH  22

// ---------------------------------------------------------------------------
// Material values in centipawns
// ---------------------------------------------------------------------------

`define VALUE_PAWN     100
`define VALUE_KNIGHT   310
`define VALUE_BISHOP   320
`define VALUE_ROOK     500
`define VALUE_QUEEN    900
// King value dominates any sum of the other pieces.
`define VALUE_KING   10000

`endif
